/* rtl/cp0Pkg.sv */
`default_nettype none

package cp0Pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [4:0]  excCode_t;
    typedef logic [5:0]  hwInt_t;
    typedef logic [7:0]  intPend_t;   // Cause IP7..IP0
    typedef logic [7:0]  intMask_t;   // Status IM7..IM0
    typedef logic [9:0]  excFlags_t;

    // Listed from highest to lowest priority
    typedef enum logic [3:0] {
        excNone,
        excInterrupt,
        excFetchAddr,
        excReserved,
        excSyscall,
        excBreak,
        excEret,
        excTrap,
        excOverflow,
        excStoreAddr,
        excLoadAddr
    } excKind_t;

    typedef enum logic {
        modeNormal,
        modeExcLevel
    } cp0Mode_t;

    // Bit positions in excFlags
    localparam int FLAG_INTERRUPT = 0;
    localparam int FLAG_FETCHADDR = 1;
    localparam int FLAG_RESERVED  = 2;
    localparam int FLAG_SYSCALL   = 3;
    localparam int FLAG_BREAK     = 4;
    localparam int FLAG_ERET      = 5;
    localparam int FLAG_TRAP      = 6;
    localparam int FLAG_OVERFLOW  = 7;
    localparam int FLAG_STOREADDR = 8;
    localparam int FLAG_LOADADDR  = 9;

    localparam regAddr_t REG_BADVADDR = 5'd8;
    localparam regAddr_t REG_COUNT    = 5'd9;
    localparam regAddr_t REG_COMPARE  = 5'd11;
    localparam regAddr_t REG_STATUS   = 5'd12;
    localparam regAddr_t REG_CAUSE    = 5'd13;
    localparam regAddr_t REG_EPC      = 5'd14;

    localparam excCode_t CODE_INT  = 5'h00;
    localparam excCode_t CODE_ADEL = 5'h04;
    localparam excCode_t CODE_ADES = 5'h05;
    localparam excCode_t CODE_SYS  = 5'h08;
    localparam excCode_t CODE_BP   = 5'h09;
    localparam excCode_t CODE_RI   = 5'h0a;
    localparam excCode_t CODE_OV   = 5'h0c;
    localparam excCode_t CODE_TR   = 5'h0d;

    localparam word_t DELAY_SLOT_OFFSET = 32'd4;  // Branch sits one word before the slot

endpackage

`default_nettype wire

/* rtl/excControl.sv */
`default_nettype none
`timescale 1ns/1ps

module excControl (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              wrEn,
    input  wire cp0Pkg::regAddr_t  wrAddr,
    input  wire cp0Pkg::word_t     wrData,
    input  wire cp0Pkg::excFlags_t excFlags,
    input  wire logic              inDelaySlot,
    output logic                   wrStatus,
    output logic                   wrCause,
    output logic                   wrEpc,
    output logic                   wrCount,
    output logic                   wrCompare,
    output logic                   epcLoad,
    output logic                   badFromPc,
    output logic                   badFromData,
    output logic                   statusExl,
    output logic                   causeBd,
    output cp0Pkg::excCode_t       causeExcCode
);

    cp0Pkg::excKind_t kind;
    cp0Pkg::cp0Mode_t mode;
    cp0Pkg::cp0Mode_t nextMode;
    logic             excTaken;      // Any kind other than Eret

    // Register write strobes
    assign wrStatus  = wrEn && (wrAddr == cp0Pkg::REG_STATUS);
    assign wrCause   = wrEn && (wrAddr == cp0Pkg::REG_CAUSE);
    assign wrEpc     = wrEn && (wrAddr == cp0Pkg::REG_EPC);
    assign wrCount   = wrEn && (wrAddr == cp0Pkg::REG_COUNT);
    assign wrCompare = wrEn && (wrAddr == cp0Pkg::REG_COMPARE);

    always_comb begin
        if (excFlags[cp0Pkg::FLAG_INTERRUPT])      kind = cp0Pkg::excInterrupt;
        else if (excFlags[cp0Pkg::FLAG_FETCHADDR]) kind = cp0Pkg::excFetchAddr;
        else if (excFlags[cp0Pkg::FLAG_RESERVED])  kind = cp0Pkg::excReserved;
        else if (excFlags[cp0Pkg::FLAG_SYSCALL])   kind = cp0Pkg::excSyscall;
        else if (excFlags[cp0Pkg::FLAG_BREAK])     kind = cp0Pkg::excBreak;
        else if (excFlags[cp0Pkg::FLAG_ERET])      kind = cp0Pkg::excEret;
        else if (excFlags[cp0Pkg::FLAG_TRAP])      kind = cp0Pkg::excTrap;
        else if (excFlags[cp0Pkg::FLAG_OVERFLOW])  kind = cp0Pkg::excOverflow;
        else if (excFlags[cp0Pkg::FLAG_STOREADDR]) kind = cp0Pkg::excStoreAddr;
        else if (excFlags[cp0Pkg::FLAG_LOADADDR])  kind = cp0Pkg::excLoadAddr;
        else                                       kind = cp0Pkg::excNone;
    end

    assign excTaken    = (kind != cp0Pkg::excNone) && (kind != cp0Pkg::excEret);
    assign statusExl   = (mode == cp0Pkg::modeExcLevel);
    assign epcLoad     = excTaken && !statusExl;  // No EPC update when nested
    assign badFromPc   = (kind == cp0Pkg::excFetchAddr);
    assign badFromData = (kind == cp0Pkg::excStoreAddr) || (kind == cp0Pkg::excLoadAddr);

    // EXL machine where exceptions override a Status write
    always_comb begin
        nextMode = mode;
        case (mode)
            cp0Pkg::modeNormal: begin
                if (excTaken)                  nextMode = cp0Pkg::modeExcLevel;
                else if (kind == cp0Pkg::excEret) nextMode = cp0Pkg::modeNormal;
                else if (wrStatus && wrData[1]) nextMode = cp0Pkg::modeExcLevel;
            end
            cp0Pkg::modeExcLevel: begin
                if (kind == cp0Pkg::excEret)    nextMode = cp0Pkg::modeNormal;
                else if (excTaken)              nextMode = cp0Pkg::modeExcLevel;
                else if (wrStatus && !wrData[1]) nextMode = cp0Pkg::modeNormal;
            end
            default: nextMode = cp0Pkg::modeNormal;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= cp0Pkg::modeNormal;
        end else begin
            mode <= nextMode;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            causeBd <= 1'b0;
        end else if (epcLoad) begin
            causeBd <= inDelaySlot;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            causeExcCode <= '0;
        end else begin
            case (kind)
                cp0Pkg::excInterrupt: causeExcCode <= cp0Pkg::CODE_INT;
                cp0Pkg::excFetchAddr: causeExcCode <= cp0Pkg::CODE_ADEL;
                cp0Pkg::excReserved:  causeExcCode <= cp0Pkg::CODE_RI;
                cp0Pkg::excSyscall:   causeExcCode <= cp0Pkg::CODE_SYS;
                cp0Pkg::excBreak:     causeExcCode <= cp0Pkg::CODE_BP;
                cp0Pkg::excTrap:      causeExcCode <= cp0Pkg::CODE_TR;
                cp0Pkg::excOverflow:  causeExcCode <= cp0Pkg::CODE_OV;
                cp0Pkg::excStoreAddr: causeExcCode <= cp0Pkg::CODE_ADES;
                cp0Pkg::excLoadAddr:  causeExcCode <= cp0Pkg::CODE_ADEL;
                default:              causeExcCode <= causeExcCode;  // None or Eret
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/cp0Timer.sv */
`default_nettype none
`timescale 1ns/1ps

module cp0Timer (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          wrCount,
    input  wire logic          wrCompare,
    input  wire cp0Pkg::word_t wrData,
    output cp0Pkg::word_t      count,
    output cp0Pkg::word_t      compare,
    output logic               timerIrq,
    output logic               causeTi
);

    logic halfTick;  // Count advances when this is set

    always_ff @(posedge clk) begin
        if (rst) begin
            halfTick <= 1'b0;
            count    <= '0;
        end else if (wrCount) begin
            halfTick <= 1'b0;
            count    <= wrData;
        end else begin
            halfTick <= ~halfTick;
            if (halfTick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            compare <= '0;
        end else if (wrCompare) begin
            compare <= wrData;
        end
    end

    assign timerIrq = (count == compare);

    // Sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (rst) begin
            causeTi <= 1'b0;
        end else if (wrCompare) begin
            causeTi <= 1'b0;
        end else if (timerIrq) begin
            causeTi <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/excAddrRegs.sv */
`default_nettype none
`timescale 1ns/1ps

module excAddrRegs (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          epcLoad,
    input  wire logic          wrEpc,
    input  wire logic          badFromPc,
    input  wire logic          badFromData,
    input  wire logic          inDelaySlot,
    input  wire cp0Pkg::word_t excPc,
    input  wire cp0Pkg::word_t excBadAddr,
    input  wire cp0Pkg::word_t wrData,
    output cp0Pkg::word_t      epc,
    output cp0Pkg::word_t      badVAddr
);

    cp0Pkg::word_t restartPc;

    // Delay slot restarts at the branch
    assign restartPc = inDelaySlot ? (excPc - cp0Pkg::DELAY_SLOT_OFFSET) : excPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (epcLoad) begin
            epc <= restartPc;
        end else if (wrEpc) begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            badVAddr <= '0;
        end else if (badFromPc) begin
            badVAddr <= excPc;        // Fetch address error
        end else if (badFromData) begin
            badVAddr <= excBadAddr;
        end
    end

endmodule

`default_nettype wire

/* rtl/statusCauseRegs.sv */
`default_nettype none
`timescale 1ns/1ps

module statusCauseRegs (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           wrStatus,
    input  wire logic           wrCause,
    input  wire cp0Pkg::word_t  wrData,
    input  wire cp0Pkg::hwInt_t hwInt,
    input  wire logic           timerIrq,
    output cp0Pkg::intMask_t    statusIm,
    output logic                statusIe,
    output cp0Pkg::intPend_t    causeIp
);

    cp0Pkg::hwInt_t ipHw;   // IP7..IP2
    logic [1:0]     ipSw;   // IP1..IP0

    always_ff @(posedge clk) begin
        if (rst) begin
            statusIm <= '0;
            statusIe <= 1'b0;
        end else if (wrStatus) begin
            statusIm <= wrData[15:8];
            statusIe <= wrData[0];
        end
    end

    // Timer shares the IP7 line
    always_ff @(posedge clk) begin
        if (rst) begin
            ipHw <= '0;
        end else begin
            ipHw <= hwInt | {timerIrq, 5'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ipSw <= '0;
        end else if (wrCause) begin
            ipSw <= wrData[9:8];
        end
    end

    assign causeIp = {ipHw, ipSw};

endmodule

`default_nettype wire

/* rtl/cp0ReadMux.sv */
`default_nettype none
`timescale 1ns/1ps

module cp0ReadMux (
    input  wire cp0Pkg::regAddr_t rdAddr,
    input  wire cp0Pkg::intMask_t statusIm,
    input  wire logic             statusExl,
    input  wire logic             statusIe,
    input  wire logic             causeBd,
    input  wire logic             causeTi,
    input  wire cp0Pkg::intPend_t causeIp,
    input  wire cp0Pkg::excCode_t causeExcCode,
    input  wire cp0Pkg::word_t    epc,
    input  wire cp0Pkg::word_t    badVAddr,
    input  wire cp0Pkg::word_t    count,
    input  wire cp0Pkg::word_t    compare,
    output cp0Pkg::word_t         rdData
);

    cp0Pkg::word_t statusWord;
    cp0Pkg::word_t causeWord;

    // BEV is hardwired at bit 22
    assign statusWord = {9'b0, 1'b1, 6'b0, statusIm, 6'b0, statusExl, statusIe};
    assign causeWord  = {causeBd, causeTi, 14'b0, causeIp, 1'b0, causeExcCode, 2'b0};

    always_comb begin
        case (rdAddr)
            cp0Pkg::REG_BADVADDR: rdData = badVAddr;
            cp0Pkg::REG_COUNT:    rdData = count;
            cp0Pkg::REG_COMPARE:  rdData = compare;
            cp0Pkg::REG_STATUS:   rdData = statusWord;
            cp0Pkg::REG_CAUSE:    rdData = causeWord;
            cp0Pkg::REG_EPC:      rdData = epc;
            default:              rdData = '0;  // Unmapped
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cp0Top.sv */
`default_nettype none
`timescale 1ns/1ps

module cp0Top (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire cp0Pkg::hwInt_t    hwInt,
    input  wire cp0Pkg::regAddr_t  rdAddr,
    output cp0Pkg::word_t          rdData,
    input  wire logic              wrEn,
    input  wire cp0Pkg::regAddr_t  wrAddr,
    input  wire cp0Pkg::word_t     wrData,
    input  wire cp0Pkg::excFlags_t excFlags,
    input  wire cp0Pkg::word_t     excPc,
    input  wire cp0Pkg::word_t     excBadAddr,
    input  wire logic              inDelaySlot,
    output cp0Pkg::intMask_t       statusIm,
    output logic                   statusExl,
    output logic                   statusIe,
    output cp0Pkg::intPend_t       causeIp,
    output cp0Pkg::word_t          epc
);

    logic             wrStatus;
    logic             wrCause;
    logic             wrEpc;
    logic             wrCount;
    logic             wrCompare;
    logic             epcLoad;
    logic             badFromPc;
    logic             badFromData;
    logic             causeBd;
    logic             causeTi;
    logic             timerIrq;
    cp0Pkg::excCode_t causeExcCode;
    cp0Pkg::word_t    count;
    cp0Pkg::word_t    compare;
    cp0Pkg::word_t    badVAddr;

    excControl u_excControl (
        .clk          (clk),
        .rst          (rst),
        .wrEn         (wrEn),
        .wrAddr       (wrAddr),
        .wrData       (wrData),
        .excFlags     (excFlags),
        .inDelaySlot  (inDelaySlot),
        .wrStatus     (wrStatus),
        .wrCause      (wrCause),
        .wrEpc        (wrEpc),
        .wrCount      (wrCount),
        .wrCompare    (wrCompare),
        .epcLoad      (epcLoad),
        .badFromPc    (badFromPc),
        .badFromData  (badFromData),
        .statusExl    (statusExl),
        .causeBd      (causeBd),
        .causeExcCode (causeExcCode)
    );

    cp0Timer u_cp0Timer (
        .clk       (clk),
        .rst       (rst),
        .wrCount   (wrCount),
        .wrCompare (wrCompare),
        .wrData    (wrData),
        .count     (count),
        .compare   (compare),
        .timerIrq  (timerIrq),
        .causeTi   (causeTi)
    );

    excAddrRegs u_excAddrRegs (
        .clk         (clk),
        .rst         (rst),
        .epcLoad     (epcLoad),
        .wrEpc       (wrEpc),
        .badFromPc   (badFromPc),
        .badFromData (badFromData),
        .inDelaySlot (inDelaySlot),
        .excPc       (excPc),
        .excBadAddr  (excBadAddr),
        .wrData      (wrData),
        .epc         (epc),
        .badVAddr    (badVAddr)
    );

    statusCauseRegs u_statusCauseRegs (
        .clk      (clk),
        .rst      (rst),
        .wrStatus (wrStatus),
        .wrCause  (wrCause),
        .wrData   (wrData),
        .hwInt    (hwInt),
        .timerIrq (timerIrq),
        .statusIm (statusIm),
        .statusIe (statusIe),
        .causeIp  (causeIp)
    );

    cp0ReadMux u_cp0ReadMux (
        .rdAddr       (rdAddr),
        .statusIm     (statusIm),
        .statusExl    (statusExl),
        .statusIe     (statusIe),
        .causeBd      (causeBd),
        .causeTi      (causeTi),
        .causeIp      (causeIp),
        .causeExcCode (causeExcCode),
        .epc          (epc),
        .badVAddr     (badVAddr),
        .count        (count),
        .compare      (compare),
        .rdData       (rdData)
    );

endmodule

`default_nettype wire

/* verification/cp0Top_assertions.sv */
`default_nettype none
`timescale 1ns/1ps

module cp0Assertions (
    input wire logic              clk,
    input wire logic              rst,
    input wire cp0Pkg::excFlags_t excFlags,
    input wire logic              wrEn,
    input wire cp0Pkg::regAddr_t  wrAddr,
    input wire logic              statusExl,
    input wire logic              timerIrq,
    input wire logic              causeTi
);

    int   failures = 0;
    logic eretWins;      // Eret with no higher flag set
    logic excWins;
    logic compareWrite;

    assign eretWins = excFlags[cp0Pkg::FLAG_ERET]
        && (excFlags[cp0Pkg::FLAG_BREAK:cp0Pkg::FLAG_INTERRUPT] == '0);
    assign excWins      = (|excFlags) && !eretWins;
    assign compareWrite = wrEn && (wrAddr == cp0Pkg::REG_COMPARE);

    excSetsExl: assert property (@(posedge clk) disable iff (rst) excWins |=> statusExl)
        else begin
            $error("statusExl low after an exception");
            failures++;
        end

    eretClearsExl: assert property (@(posedge clk) disable iff (rst) eretWins |=> !statusExl)
        else begin
            $error("statusExl high after Eret");
            failures++;
        end

    // Compare write in the same cycle clears TI instead
    matchSetsTi: assert property (@(posedge clk) disable iff (rst)
        (timerIrq && !compareWrite) |=> causeTi)
        else begin
            $error("TI not set after a timer match");
            failures++;
        end

endmodule

bind cp0Top cp0Assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .excFlags  (excFlags),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .statusExl (statusExl),
    .timerIrq  (timerIrq),
    .causeTi   (causeTi)
);

`default_nettype wire

/* verification/cp0Tb.sv */
`default_nettype none
`timescale 1ns/1ps

module cp0Tb;

    localparam int CLK_HALF        = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int WATCHDOG_CYCLES = 2000;

    logic              clk;
    logic              rst;
    cp0Pkg::hwInt_t    hwInt;
    cp0Pkg::regAddr_t  rdAddr;
    cp0Pkg::word_t     rdData;
    logic              wrEn;
    cp0Pkg::regAddr_t  wrAddr;
    cp0Pkg::word_t     wrData;
    cp0Pkg::excFlags_t excFlags;
    cp0Pkg::word_t     excPc;
    cp0Pkg::word_t     excBadAddr;
    logic              inDelaySlot;
    cp0Pkg::intMask_t  statusIm;
    logic              statusExl;
    logic              statusIe;
    cp0Pkg::intPend_t  causeIp;
    cp0Pkg::word_t     epc;

    int         fd;
    int         code;
    logic [7:0] cmd;

    cp0Top DUT (
        .clk         (clk),
        .rst         (rst),
        .hwInt       (hwInt),
        .rdAddr      (rdAddr),
        .rdData      (rdData),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .excFlags    (excFlags),
        .excPc       (excPc),
        .excBadAddr  (excBadAddr),
        .inDelaySlot (inDelaySlot),
        .statusIm    (statusIm),
        .statusExl   (statusExl),
        .statusIe    (statusIe),
        .causeIp     (causeIp),
        .epc         (epc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    task automatic abortRun();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input cp0Pkg::word_t got,
                              input cp0Pkg::word_t want);
        assert (got === want) else begin
            $display("[FAIL] %s = %h, expected %h", name, got, want);
            abortRun();
        end
    endtask

    task automatic requireFields(input int got, input int want);
        assert (got == want) else begin
            $display("Malformed vector line, expected %0d fields", want);
            abortRun();
        end
    endtask

    task automatic checkPort(input logic [8*16-1:0] port, input cp0Pkg::word_t want);
        if (port == "statusIm") checkEqual("statusIm", 32'(statusIm), want);
        else if (port == "statusExl") checkEqual("statusExl", 32'(statusExl), want);
        else if (port == "statusIe") checkEqual("statusIe", 32'(statusIe), want);
        else if (port == "causeIp") checkEqual("causeIp", 32'(causeIp), want);
        else if (port == "epc") checkEqual("epc", epc, want);
        else begin
            $display("Vector file names an unknown output port");
            abortRun();
        end
    endtask

    task automatic applyWrite(input cp0Pkg::regAddr_t addr, input cp0Pkg::word_t data);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrData = data;
        @(negedge clk);
        wrEn   = 1'b0;
    endtask

    task automatic applyException(input cp0Pkg::excFlags_t flags, input cp0Pkg::word_t pc,
                                  input cp0Pkg::word_t badAddr, input logic slot);
        excFlags    = flags;
        excPc       = pc;
        excBadAddr  = badAddr;
        inDelaySlot = slot;
        @(negedge clk);
        excFlags    = '0;  // Flag vector lasts one cycle
    endtask

    // Each command runs in the low clock phase
    task automatic runCommand(input logic [7:0] op);
        cp0Pkg::word_t    a;
        cp0Pkg::word_t    b;
        cp0Pkg::word_t    c;
        cp0Pkg::word_t    d;
        logic [8*16-1:0]  port;
        int               cnt;
        int               fields;
        int               ch;
        case (op)
            "#": begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end
            "W": begin
                fields = $fscanf(fd, "%h %h", a, b);
                requireFields(fields, 2);
                applyWrite(a[4:0], b);
            end
            "X": begin
                fields = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                requireFields(fields, 4);
                applyException(a[9:0], b, c, d[0]);
            end
            "I": begin
                fields = $fscanf(fd, "%h", a);
                requireFields(fields, 1);
                hwInt = a[5:0];
            end
            "N": begin
                fields = $fscanf(fd, "%d", cnt);
                requireFields(fields, 1);
                repeat (cnt) @(negedge clk);
            end
            "R": begin
                fields = $fscanf(fd, "%h %h", a, b);
                requireFields(fields, 2);
                rdAddr = a[4:0];
                #1;
                checkEqual("rdData", rdData, b);
            end
            "O": begin
                fields = $fscanf(fd, "%s %h", port, a);
                requireFields(fields, 2);
                #1;
                checkPort(port, a);
            end
            "C": begin
                fields = $fscanf(fd, "%h %h", a, b);
                requireFields(fields, 2);
                rdAddr = cp0Pkg::REG_COUNT;
                #1;
                assert (rdData >= a && rdData <= b) else begin
                    $display("[FAIL] rdData (Count) = %h, expected %h..%h", rdData, a, b);
                    abortRun();
                end
            end
            default: begin
                $display("Vector file holds an unknown command %c", op);
                abortRun();
            end
        endcase
    endtask

    initial begin
        rst         = 1'b1;
        hwInt       = '0;
        rdAddr      = '0;
        wrEn        = 1'b0;
        wrAddr      = '0;
        wrData      = '0;
        excFlags    = '0;
        excPc       = '0;
        excBadAddr  = '0;
        inDelaySlot = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verification/cp0Vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            abortRun();
        end
        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            runCommand(cmd);
            code = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);
        @(negedge clk);  // One more edge for pending assertion attempts

        if (DUT.u_assertions.failures == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", DUT.u_assertions.failures);
            abortRun();
        end
    end

    always @(DUT.u_assertions.failures) begin
        if (DUT.u_assertions.failures != 0) begin
            $display("Bound assertion on the DUT failed");
            abortRun();
        end
    end

    initial begin : watchdog
        int cycles;
        for (cycles = 0; cycles < WATCHDOG_CYCLES; cycles++) begin
            @(posedge clk);
        end
        $display("Run did not finish within %0d cycles", WATCHDOG_CYCLES);
        abortRun();
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/cp0Pkg.sv
rtl/excControl.sv
rtl/cp0Timer.sv
rtl/excAddrRegs.sv
rtl/statusCauseRegs.sv
rtl/cp0ReadMux.sv
rtl/cp0Top.sv
verification/cp0Top_assertions.sv
verification/cp0Tb.sv

/* verification/cp0Vectors.txt */
# W addr data | X flags pc badAddr delaySlot | I hwInt | N cycles (decimal)
# R addr expect | O port expect | C countLo countHi; all other numbers are hex
O statusExl 0
O statusIe 0
O statusIm 0
R 0c 00400000
W 0b ffff0000
R 0b ffff0000
W 0c 0000ff01
R 0c 0040ff01
O statusIm ff
O statusIe 1
W 0d 00000300
R 0d 00000300
W 0e 12345678
R 0e 12345678
O epc 12345678
R 0a 00000000
# syscall outranks trap and overflow
X 0c8 00400100 00000000 0
O statusExl 1
O epc 00400100
R 0c 0040ff03
R 0d 00000320
X 020 00000000 00000000 0
O statusExl 0
R 0d 00000320
# overflow in a delay slot
X 280 00400208 00000000 1
O epc 00400204
R 0d 80000330
R 08 00000000
# nested break keeps EPC and BD
X 010 00400300 00000000 0
O epc 00400204
R 0d 80000324
X 020 00000000 00000000 0
O statusExl 0
X 030 00400400 00000000 0
O statusExl 1
O epc 00400400
R 0d 00000324
X 020 00000000 00000000 0
# address errors
X 002 00400403 00000000 0
R 08 00400403
R 0d 00000310
X 020 00000000 00000000 0
X 200 00400500 10000001 0
R 08 10000001
R 0d 00000310
X 100 00400600 10000002 0
R 08 10000002
R 0d 00000314
O epc 00400500
X 020 00000000 00000000 0
O statusExl 0
# Count and timer
W 09 00001000
C 00001000 00001000
N 5
C 00001002 00001002
N 4
C 00001003 00001005
W 0b 00001008
R 0d 00000314
N 7
R 0d 40008314
O causeIp 83
W 0b 00002000
R 0d 00008314
N 1
R 0d 00000314
# hardware interrupt lines
I 2a
N 1
O causeIp ab
I 15
O causeIp ab
N 1
O causeIp 57
I 00
N 1
O causeIp 03
